/* flist.f */
+incdir+common
common/uart_pkg.sv
source/sync_fifo.sv
uart_tx/uart_tx.sv
uart_rx/uart_rx.sv
source/uart_top.sv
sim/tb_uart.sv

/* Makefile */
# Verilator build and run of the UART core testbench

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f flist.f --top-module tb_uart -Mdir obj_dir -o sim_uart

run: compile
	./obj_dir/sim_uart | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* sim/tb_uart.sv */
//****************************************
// uart testbench
// directed tests of the UART core with a
// loopback path and a serial line driver
//****************************************
`include "uart_params.svh"

module tb_uart;

    localparam int CLK_HALF   = 50;
    localparam int DRIVE_DLY  = 10;
    localparam int BAUD       = 8;
    // about 25 frames of 11 bits, doubled, plus reset and drain
    localparam int MAX_FRAMES = 25;
    localparam int TIMEOUT_CYCLES = 2 * MAX_FRAMES * 11 * BAUD + 600;

    logic                        clk;
    logic                        rst_n;
    logic [`UART_BAUD_DIV_W-1:0] baud_div_i;
    logic                        two_stop_bits_i;
    logic [`UART_DATA_BITS-1:0]  tx_data_i;
    logic                        tx_valid_i;
    logic                        tx_ready_o;
    logic [`UART_DATA_BITS-1:0]  rx_data_o;
    logic                        rx_frame_err_o;
    logic                        rx_valid_o;
    logic                        rx_ready_i;
    logic                        rx_overrun_o;
    logic                        rx_pin_i;
    logic                        tx_pin_o;

    // loopback or testbench serial driver on rx_pin_i
    logic loop_en;
    logic drv_pin;

    int cycle_cnt    = 0;
    int err_cnt      = 0;
    int tests_run    = 0;
    int tests_failed = 0;

    // tx line monitor
    logic line_prev;
    int   run_len;
    int   busy_left;
    int   overrun_cnt;
    int   runs[$];
    int   start_cycles[$];

    assign rx_pin_i = loop_en ? tx_pin_o : drv_pin;

    uart_top UUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .baud_div_i      (baud_div_i),
        .two_stop_bits_i (two_stop_bits_i),
        .tx_data_i       (tx_data_i),
        .tx_valid_i      (tx_valid_i),
        .tx_ready_o      (tx_ready_o),
        .rx_data_o       (rx_data_o),
        .rx_frame_err_o  (rx_frame_err_o),
        .rx_valid_o      (rx_valid_o),
        .rx_ready_i      (rx_ready_i),
        .rx_overrun_o    (rx_overrun_o),
        .rx_pin_i        (rx_pin_i),
        .tx_pin_o        (tx_pin_o)
    );

    //****************************************
    // clock, timeout and line monitor
    //****************************************

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycle_cnt);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // run lengths between transitions, start edges and overrun pulses
    always @(negedge clk) begin
        if (!rst_n) begin
            line_prev   = 1'b1;
            run_len     = 0;
            busy_left   = 0;
            overrun_cnt = 0;
        end else begin
            if (busy_left > 0) begin
                busy_left = busy_left - 1;
            end
            if (tx_pin_o != line_prev) begin
                runs.push_back(run_len);
                // a fall outside start plus data bits opens a frame
                if (!tx_pin_o && busy_left == 0) begin
                    start_cycles.push_back(cycle_cnt);
                    busy_left = 9 * BAUD;
                end
                run_len = 1;
            end else begin
                run_len = run_len + 1;
            end
            line_prev = tx_pin_o;
            if (rx_overrun_o) begin
                overrun_cnt = overrun_cnt + 1;
            end
        end
    end

    //****************************************
    // helpers
    //****************************************

    task automatic step();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic send_byte(input logic [7:0] b);
        tx_data_i  = b;
        tx_valid_i = 1'b1;
        @(negedge clk);
        while (!tx_ready_o) begin
            @(negedge clk);
        end
        step();
        tx_valid_i = 1'b0;
    endtask

    task automatic recv_word(output logic [7:0] data, output logic err);
        rx_ready_i = 1'b1;
        @(negedge clk);
        while (!rx_valid_o) begin
            @(negedge clk);
        end
        data = rx_data_o;
        err  = rx_frame_err_o;
        step();
        rx_ready_i = 1'b0;
    endtask

    // start, eight data bits LSB first, one stop bit, one idle bit
    task automatic drive_frame(input logic [7:0] b, input logic stop_val);
        drv_pin = 1'b0;
        repeat (BAUD) step();
        for (int i = 0; i < 8; i++) begin
            drv_pin = b[i];
            repeat (BAUD) step();
        end
        drv_pin = stop_val;
        repeat (BAUD) step();
        drv_pin = 1'b1;
        repeat (BAUD) step();
    endtask

    // longer high run than any frame can hold
    task automatic wait_line_quiet();
        while (!(line_prev && run_len > 12 * BAUD)) begin
            @(negedge clk);
        end
        step();
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run = tests_run + 1;
        if (err_cnt != errs_before) begin
            tests_failed = tests_failed + 1;
        end
        $display("test %0d %s: %0d errors", tests_run, name, err_cnt - errs_before);
    endtask

    //****************************************
    // tests
    //****************************************

    task automatic check_reset_state();
        int e0;
        e0 = err_cnt;
        @(negedge clk);
        if (tx_pin_o !== 1'b1) begin
            $display("FAIL %0t tx_pin_o: got %b expected 1", $time, tx_pin_o);
            err_cnt++;
        end
        if (tx_ready_o !== 1'b1) begin
            $display("FAIL %0t tx_ready_o: got %b expected 1", $time, tx_ready_o);
            err_cnt++;
        end
        if (rx_valid_o !== 1'b0) begin
            $display("FAIL %0t rx_valid_o: got %b expected 0", $time, rx_valid_o);
            err_cnt++;
        end
        if (rx_overrun_o !== 1'b0) begin
            $display("FAIL %0t rx_overrun_o: got %b expected 0", $time, rx_overrun_o);
            err_cnt++;
        end
        step();
        end_test("reset state", e0);
    endtask

    task automatic loopback_single_byte();
        logic [7:0] b;
        logic [7:0] got;
        logic       err;
        int         e0;
        int         r0;
        e0 = err_cnt;
        loop_en = 1'b1;
        two_stop_bits_i = 1'b0;
        // LSB of one ends the start bit after one bit time
        b  = 8'($urandom) | 8'h01;
        r0 = runs.size();
        send_byte(b);
        recv_word(got, err);
        if (got !== b) begin
            $display("FAIL %0t rx_data_o: got %h expected %h", $time, got, b);
            err_cnt++;
        end
        if (err !== 1'b0) begin
            $display("FAIL %0t rx_frame_err_o: got %b expected 0", $time, err);
            err_cnt++;
        end
        if (runs.size() < r0 + 2) begin
            $display("%0t: no complete start bit seen on tx_pin_o", $time);
            err_cnt++;
        end else begin
            if (runs[r0 + 1] != BAUD) begin
                $display("FAIL %0t tx_pin_o start bit: got %0d expected %0d",
                         $time, runs[r0 + 1], BAUD);
                err_cnt++;
            end
            for (int i = r0 + 2; i < runs.size(); i++) begin
                if (runs[i] % BAUD != 0) begin
                    $display("FAIL %0t tx_pin_o run length: got %0d expected multiple of %0d",
                             $time, runs[i], BAUD);
                    err_cnt++;
                end
            end
        end
        end_test("single byte", e0);
    endtask

    task automatic burst_with_backpressure();
        logic [7:0] sent[4];
        logic [7:0] got[$];
        int         e0;
        int         s0;
        int         d;
        e0 = err_cnt;
        loop_en = 1'b1;
        two_stop_bits_i = 1'b1;
        for (int i = 0; i < 4; i++) begin
            sent[i] = 8'($urandom);
        end
        s0 = start_cycles.size();
        fork
            begin
                for (int i = 0; i < 4; i++) begin
                    send_byte(sent[i]);
                end
            end
            begin
                while (got.size() < 4) begin
                    @(negedge clk);
                    if (rx_valid_o && rx_ready_i) begin
                        got.push_back(rx_data_o);
                    end
                    step();
                    rx_ready_i = !rx_ready_i;
                end
                rx_ready_i = 1'b0;
            end
        join
        for (int i = 0; i < 4; i++) begin
            if (got[i] !== sent[i]) begin
                $display("FAIL %0t rx_data_o: got %h expected %h", $time, got[i], sent[i]);
                err_cnt++;
            end
        end
        if (start_cycles.size() < s0 + 4) begin
            $display("%0t: fewer than four start bits seen on tx_pin_o", $time);
            err_cnt++;
        end else begin
            for (int i = 1; i < 4; i++) begin
                d = start_cycles[s0 + i] - start_cycles[s0 + i - 1];
                if (d < 11 * BAUD || d > 11 * BAUD + 2) begin
                    $display("FAIL %0t tx_pin_o start spacing: got %0d expected %0d to %0d",
                             $time, d, 11 * BAUD, 11 * BAUD + 2);
                    err_cnt++;
                end
            end
        end
        end_test("burst and order", e0);
    endtask

    task automatic framing_error_frame();
        logic [7:0] b;
        logic [7:0] got;
        logic       err;
        int         e0;
        e0 = err_cnt;
        loop_en = 1'b0;
        b = 8'($urandom);
        // stop bit held low
        drive_frame(b, 1'b0);
        recv_word(got, err);
        if (got !== b) begin
            $display("FAIL %0t rx_data_o: got %h expected %h", $time, got, b);
            err_cnt++;
        end
        if (err !== 1'b1) begin
            $display("FAIL %0t rx_frame_err_o: got %b expected 1", $time, err);
            err_cnt++;
        end
        end_test("framing error", e0);
    endtask

    task automatic overrun_drop();
        logic [7:0] sent[5];
        logic [7:0] got;
        logic       err;
        int         e0;
        int         s0;
        int         ov0;
        int         d;
        e0 = err_cnt;
        wait_line_quiet();
        loop_en = 1'b1;
        two_stop_bits_i = 1'b0;
        rx_ready_i = 1'b0;
        s0  = start_cycles.size();
        ov0 = overrun_cnt;
        for (int i = 0; i < 5; i++) begin
            sent[i] = 8'($urandom);
            send_byte(sent[i]);
        end
        // fifth word meets a full receive FIFO
        while (overrun_cnt == ov0) begin
            @(negedge clk);
        end
        step();
        for (int i = 0; i < 4; i++) begin
            recv_word(got, err);
            if (got !== sent[i]) begin
                $display("FAIL %0t rx_data_o: got %h expected %h", $time, got, sent[i]);
                err_cnt++;
            end
        end
        @(negedge clk);
        if (overrun_cnt - ov0 != 1) begin
            $display("%0t: rx_overrun_o pulsed %0d times instead of once",
                     $time, overrun_cnt - ov0);
            err_cnt++;
        end
        if (rx_valid_o !== 1'b0) begin
            $display("FAIL %0t rx_valid_o: got %b expected 0", $time, rx_valid_o);
            err_cnt++;
        end
        if (start_cycles.size() < s0 + 5) begin
            $display("%0t: fewer than five start bits seen on tx_pin_o", $time);
            err_cnt++;
        end else begin
            for (int i = 1; i < 5; i++) begin
                d = start_cycles[s0 + i] - start_cycles[s0 + i - 1];
                if (d < 10 * BAUD || d > 10 * BAUD + 2) begin
                    $display("FAIL %0t tx_pin_o start spacing: got %0d expected %0d to %0d",
                             $time, d, 10 * BAUD, 10 * BAUD + 2);
                    err_cnt++;
                end
            end
        end
        step();
        end_test("overrun", e0);
    endtask

    //****************************************
    // main sequence
    //****************************************

    initial begin
        void'($urandom(32'h421c_3a77));
        rst_n           = 1'b0;
        baud_div_i      = `UART_BAUD_DIV_W'(BAUD);
        two_stop_bits_i = 1'b0;
        tx_data_i       = '0;
        tx_valid_i      = 1'b0;
        rx_ready_i      = 1'b0;
        drv_pin         = 1'b1;
        loop_en         = 1'b1;
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        check_reset_state();
        loopback_single_byte();
        burst_with_backpressure();
        framing_error_frame();
        overrun_drop();

        $display("tests run %0d, tests with errors %0d, check errors %0d",
                 tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* source/uart_top.sv */
//****************************************
// uart top
// transmit and receive FIFOs in front of
// the two UART engines
//****************************************
`include "uart_params.svh"

module uart_top (
    input  logic                        clk,
    input  logic                        rst_n,

    // static configuration
    input  logic [`UART_BAUD_DIV_W-1:0] baud_div_i,
    input  logic                        two_stop_bits_i,

    // host transmit port
    input  logic [`UART_DATA_BITS-1:0]  tx_data_i,
    input  logic                        tx_valid_i,
    output logic                        tx_ready_o,

    // host receive port
    output logic [`UART_DATA_BITS-1:0]  rx_data_o,
    output logic                        rx_frame_err_o,
    output logic                        rx_valid_o,
    input  logic                        rx_ready_i,
    output logic                        rx_overrun_o,

    // serial pins
    input  logic                        rx_pin_i,
    output logic                        tx_pin_o
);

    import uart_pkg::*;

    logic [`UART_DATA_BITS-1:0] tx_fifo_data;
    logic                       tx_fifo_valid;
    logic                       tx_fifo_ready;

    uart_rx_word_t              rx_word;
    logic                       rx_word_valid;
    logic                       rx_word_ready;
    uart_rx_word_t              rx_fifo_word;

    //****************************************
    // transmit path
    //****************************************

    sync_fifo #(
        .payload_t (logic [`UART_DATA_BITS-1:0]),
        .DEPTH     (`UART_FIFO_DEPTH)
    ) u_tx_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_data_i  (tx_data_i),
        .wr_valid_i (tx_valid_i),
        .wr_ready_o (tx_ready_o),
        .rd_data_o  (tx_fifo_data),
        .rd_valid_o (tx_fifo_valid),
        .rd_ready_i (tx_fifo_ready)
    );

    uart_tx u_uart_tx (
        .clk             (clk),
        .rst_n           (rst_n),
        .tx_data_i       (tx_fifo_data),
        .baud_div_i      (baud_div_i),
        .two_stop_bits_i (two_stop_bits_i),
        .valid_i         (tx_fifo_valid),
        .ready_o         (tx_fifo_ready),
        .tx_pin_o        (tx_pin_o)
    );

    //****************************************
    // receive path
    //****************************************

    uart_rx u_uart_rx (
        .clk          (clk),
        .rst_n        (rst_n),
        .rx_pin_i     (rx_pin_i),
        .baud_div_i   (baud_div_i),
        .word_o       (rx_word),
        .word_valid_o (rx_word_valid),
        .word_ready_i (rx_word_ready),
        .overrun_o    (rx_overrun_o)
    );

    sync_fifo #(
        .payload_t (uart_rx_word_t),
        .DEPTH     (`UART_FIFO_DEPTH)
    ) u_rx_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_data_i  (rx_word),
        .wr_valid_i (rx_word_valid),
        .wr_ready_o (rx_word_ready),
        .rd_data_o  (rx_fifo_word),
        .rd_valid_o (rx_valid_o),
        .rd_ready_i (rx_ready_i)
    );

    // split the stored word for the host
    assign rx_data_o      = rx_fifo_word.data;
    assign rx_frame_err_o = rx_fifo_word.frame_err;

endmodule

/* uart_rx/uart_rx.sv */
//****************************************
// uart receiver
// synchronizes the line, confirms the start
// bit, samples data at mid-bit and checks
// the stop bit before pushing a word
//****************************************
`include "uart_params.svh"

module uart_rx (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        rx_pin_i,
    input  logic [`UART_BAUD_DIV_W-1:0] baud_div_i,
    output uart_pkg::uart_rx_word_t     word_o,
    output logic                        word_valid_o,
    input  logic                        word_ready_i,
    output logic                        overrun_o
);

    import uart_pkg::*;

    localparam int IDX_W = $clog2(`UART_DATA_BITS);

    logic [1:0]                  sync_q;
    logic                        rx_s;

    uart_rx_state_e              state_q, state_d;
    logic [`UART_BAUD_DIV_W-1:0] baud_cnt_q, baud_cnt_d;
    logic [IDX_W-1:0]            idx_q, idx_d;
    logic [`UART_DATA_BITS-1:0]  data_q, data_d;
    logic                        tick;
    logic                        push;

    uart_rx_word_t               word_q;
    logic                        valid_q;

    //****************************************
    // input synchronizer
    //****************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= 2'b11;
        end else begin
            sync_q <= {sync_q[0], rx_pin_i};
        end
    end

    assign rx_s = sync_q[1];

    //****************************************
    // receive state machine
    //****************************************

    assign tick = (baud_cnt_q == `UART_BAUD_DIV_W'(1));

    always_comb begin
        state_d    = state_q;
        baud_cnt_d = baud_cnt_q;
        idx_d      = idx_q;
        data_d     = data_q;
        push       = 1'b0;

        if (state_q != rx_st_idle) begin
            baud_cnt_d = baud_cnt_q - 1'b1;
        end

        case (state_q)
            rx_st_idle: begin
                // a falling edge is trusted only after half a bit
                if (!rx_s) begin
                    baud_cnt_d = baud_div_i >> 1;
                    state_d    = rx_st_start;
                end
            end
            rx_st_start: begin
                if (tick) begin
                    if (!rx_s) begin
                        baud_cnt_d = baud_div_i;
                        idx_d      = '0;
                        state_d    = rx_st_data;
                    end else begin
                        // glitch rather than a start bit
                        state_d = rx_st_idle;
                    end
                end
            end
            rx_st_data: begin
                if (tick) begin
                    // LSB arrives first
                    data_d     = {rx_s, data_q[`UART_DATA_BITS-1:1]};
                    baud_cnt_d = baud_div_i;
                    idx_d      = idx_q + 1'b1;
                    if (idx_q == IDX_W'(`UART_DATA_BITS - 1)) begin
                        state_d = rx_st_stop;
                    end
                end
            end
            rx_st_stop: begin
                if (tick) begin
                    push    = 1'b1;
                    state_d = rx_st_idle;
                end
            end
            default: begin
                state_d = rx_st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= rx_st_idle;
            baud_cnt_q <= '0;
            idx_q      <= '0;
            valid_q    <= 1'b0;
        end else begin
            state_q    <= state_d;
            baud_cnt_q <= baud_cnt_d;
            idx_q      <= idx_d;
            valid_q    <= push;
        end
    end

    // shift register and the outgoing word
    always_ff @(posedge clk) begin
        data_q <= data_d;
        if (push) begin
            word_q.data      <= data_q;
            word_q.frame_err <= !rx_s;
        end
    end

    //****************************************
    // output push
    //****************************************

    assign word_o       = word_q;
    assign word_valid_o = valid_q;

    // a full FIFO loses the word since the push never waits
    assign overrun_o = valid_q && !word_ready_i;

endmodule

/* uart_tx/uart_tx.sv */
//****************************************
// uart transmitter
// sends start bit, eight data bits LSB
// first and one or two stop bits per byte
//****************************************
`include "uart_params.svh"

module uart_tx (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`UART_DATA_BITS-1:0]  tx_data_i,
    input  logic [`UART_BAUD_DIV_W-1:0] baud_div_i,
    input  logic                        two_stop_bits_i,
    input  logic                        valid_i,
    output logic                        ready_o,
    output logic                        tx_pin_o
);

    import uart_pkg::*;

    // start bit plus data bits
    localparam int SHIFT_W = `UART_DATA_BITS + 1;
    // wide enough for the longest frame
    localparam int CNT_W   = $clog2(`UART_DATA_BITS + 4);

    uart_tx_state_e              state_q, state_d;
    logic [`UART_BAUD_DIV_W-1:0] baud_cnt_q, baud_cnt_d;
    logic [CNT_W-1:0]            bit_cnt_q, bit_cnt_d;
    logic [SHIFT_W-1:0]          shift_q, shift_d;
    logic [CNT_W-1:0]            frame_len;
    logic [CNT_W-1:0]            stop_mark;
    logic                        bit_done;

    //****************************************
    // frame shape
    //****************************************

    // bits left in the frame, and the count at the last data bit
    assign frame_len = two_stop_bits_i ? CNT_W'(`UART_DATA_BITS + 3)
                                       : CNT_W'(`UART_DATA_BITS + 2);
    assign stop_mark = two_stop_bits_i ? CNT_W'(3) : CNT_W'(2);

    assign bit_done = (baud_cnt_q == `UART_BAUD_DIV_W'(1));

    //****************************************
    // next state
    //****************************************

    always_comb begin
        state_d    = state_q;
        baud_cnt_d = baud_cnt_q;
        bit_cnt_d  = bit_cnt_q;
        shift_d    = shift_q;

        // common bit timing for every busy state
        if (state_q != tx_st_idle) begin
            if (bit_done) begin
                baud_cnt_d = baud_div_i;
                bit_cnt_d  = bit_cnt_q - 1'b1;
                shift_d    = {1'b1, shift_q[SHIFT_W-1:1]};
            end else begin
                baud_cnt_d = baud_cnt_q - 1'b1;
            end
        end

        case (state_q)
            tx_st_idle: begin
                // byte taken on the accepting edge
                if (valid_i) begin
                    shift_d    = {tx_data_i, 1'b0};
                    bit_cnt_d  = frame_len;
                    baud_cnt_d = baud_div_i;
                    state_d    = tx_st_start;
                end
            end
            tx_st_start: begin
                if (bit_done) begin
                    state_d = tx_st_data;
                end
            end
            tx_st_data: begin
                if (bit_done && (bit_cnt_q == stop_mark)) begin
                    state_d = tx_st_stop;
                end
            end
            tx_st_stop: begin
                if (bit_done && (bit_cnt_q == CNT_W'(1))) begin
                    state_d = tx_st_idle;
                end
            end
            default: begin
                state_d = tx_st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= tx_st_idle;
            baud_cnt_q <= '0;
            bit_cnt_q  <= '0;
            // all ones keeps the line idle high
            shift_q    <= '1;
        end else begin
            state_q    <= state_d;
            baud_cnt_q <= baud_cnt_d;
            bit_cnt_q  <= bit_cnt_d;
            shift_q    <= shift_d;
        end
    end

    assign ready_o  = (state_q == tx_st_idle);
    assign tx_pin_o = shift_q[0];

endmodule

/* source/sync_fifo.sv */
//****************************************
// sync fifo
// single clock circular buffer with a
// valid/ready port on each side
//****************************************
module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  payload_t wr_data_i,
    input  logic     wr_valid_i,
    output logic     wr_ready_o,
    output payload_t rd_data_o,
    output logic     rd_valid_o,
    input  logic     rd_ready_i
);

    localparam int AW = $clog2(DEPTH);

    // entry storage
    payload_t    mem [DEPTH];

    // pointers carry one extra wrap bit
    logic [AW:0] wr_ptr_q;
    logic [AW:0] rd_ptr_q;

    logic        empty;
    logic        full;
    logic        wr_fire;
    logic        rd_fire;

    //****************************************
    // status
    //****************************************

    assign empty = (wr_ptr_q == rd_ptr_q);
    assign full  = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                   (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);

    // a read in the same cycle makes room for a write
    assign wr_ready_o = !full || rd_ready_i;
    assign rd_valid_o = !empty;
    assign rd_data_o  = mem[rd_ptr_q[AW-1:0]];

    assign wr_fire = wr_valid_i && wr_ready_o;
    assign rd_fire = rd_valid_o && rd_ready_i;

    //****************************************
    // storage and pointers
    //****************************************

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_ptr_q[AW-1:0]] <= wr_data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

endmodule

/* common/uart_pkg.sv */
//****************************************
// uart package
// state encodings of the two UART engines
// and the word kept in the receive FIFO
//****************************************
`include "uart_params.svh"

package uart_pkg;

    //****************************************
    // state machines
    //****************************************

    // one transmit state per frame section
    typedef enum logic [1:0] {
        tx_st_idle,
        tx_st_start,
        tx_st_data,
        tx_st_stop
    } uart_tx_state_e;

    // receive states where start is the half bit check
    typedef enum logic [1:0] {
        rx_st_idle,
        rx_st_start,
        rx_st_data,
        rx_st_stop
    } uart_rx_state_e;

    //****************************************
    // receive payload
    //****************************************

    // one received byte and its stop bit status
    typedef struct packed {
        logic [`UART_DATA_BITS-1:0] data;
        logic                       frame_err;
    } uart_rx_word_t;

endpackage

/* common/uart_params.svh */
//****************************************
// uart parameters
// frame width, baud divisor width and FIFO
// depth shared by the UART core
//****************************************
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

//****************************************
// frame format
//****************************************

// data bits carried in every frame
`define UART_DATA_BITS 8

//****************************************
// timing and buffering
//****************************************

// width of the clock cycles per bit divisor
`define UART_BAUD_DIV_W 16

// entries in each of the tx and rx FIFOs as a power of two
`define UART_FIFO_DEPTH 4

`endif
